//--- include/llbank_defines.svh
/*
  Build-time parameters of the linked-list response queue bank.
  Include this header wherever queue counts, widths or the RAM depth are needed.
*/
`ifndef LLBANK_DEFINES_SVH
`define LLBANK_DEFINES_SVH

// Identifier field width, sits in the low bits of every message
`define LLB_ID_WIDTH 4

// Full message width, identifier included
`define LLB_MSG_WIDTH 32

// Shared RAM entries across all queues, small so that full is easy to reach
`define LLB_CAPACITY 16

// Derived sizes
`define LLB_NUM_IDS (1 << `LLB_ID_WIDTH)
`define LLB_ADDR_WIDTH $clog2(`LLB_CAPACITY)

`endif

//--- hw/llbank_pkg.sv
/*
  Common types of the response queue bank.
  Import into any module that handles identifiers, payloads or RAM indices.
*/
`include "llbank_defines.svh"

package llbank_pkg;

  // Identifier of a queue
  typedef logic [`LLB_ID_WIDTH-1:0] id_t;

  // Message body without the identifier field
  typedef logic [`LLB_MSG_WIDTH-`LLB_ID_WIDTH-1:0] payload_t;

  // Index into the shared payload and next-pointer RAMs
  typedef logic [`LLB_ADDR_WIDTH-1:0] addr_t;

  // List length, one extra bit so a list spanning the whole RAM fits
  typedef logic [`LLB_ADDR_WIDTH:0] len_t;

  // One bit per queue
  // Release mask, candidate set and grant all use this
  typedef logic [`LLB_NUM_IDS-1:0] id_mask_t;

  // Wire format of a message, identifier in the low bits
  typedef struct packed {
    payload_t payload;
    id_t      id;
  } msg_t;

endpackage

//--- hw/llbank_ram_2p.sv
/*
  Simple dual-port RAM, one write port and one registered read port.
  Write data shows up on the read port from the next cycle on.
*/
module llbank_ram_2p #(
  parameter int Width = 8,
  parameter int Depth = 16
) (
  input  logic                     clk_i,

  // Write port
  input  logic                     wr_en_i,
  input  logic [$clog2(Depth)-1:0] wr_addr_i,
  input  logic [Width-1:0]         wr_data_i,

  // Read port, data one cycle after the enable
  input  logic                     rd_en_i,
  input  logic [$clog2(Depth)-1:0] rd_addr_i,
  output logic [Width-1:0]         rd_data_o
);

  // Storage array
  logic [Width-1:0] mem_q [Depth];

  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      mem_q[wr_addr_i] <= wr_data_i;
    end
  end

  // Read data holds its value while no read is issued
  always_ff @(posedge clk_i) begin
    if (rd_en_i) begin
      rd_data_o <= mem_q[rd_addr_i];
    end
  end

endmodule

//--- hw/llbank_free_map.sv
/*
  Occupancy tracking for the shared RAM entries.
  Offers the lowest free entry and takes alloc and free strobes from the list controller.
*/
`include "llbank_defines.svh"

module llbank_free_map (
  input  logic              clk_i,
  input  logic              rst_ni,

  // Take the entry on next_free_o
  input  logic              alloc_i,
  // Release the entry on free_addr_i
  input  logic              free_i,
  input  llbank_pkg::addr_t free_addr_i,

  output llbank_pkg::addr_t next_free_o,
  output logic              has_free_o
);

  import llbank_pkg::*;

  // One bit per RAM entry, set while the entry holds a message
  logic [`LLB_CAPACITY-1:0] used_q;
  logic [`LLB_CAPACITY-1:0] used_d;

  // Lowest clear bit, scanned from the top so the smallest index wins
  always_comb begin
    next_free_o = '0;
    for (int i = `LLB_CAPACITY - 1; i >= 0; i--) begin
      if (!used_q[i]) begin
        next_free_o = addr_t'(i);
      end
    end
  end

  assign has_free_o = ~&used_q;

  // Alloc and free never touch the same entry in one cycle
  always_comb begin
    used_d = used_q;
    if (alloc_i) begin
      used_d[next_free_o] = 1'b1;
    end
    if (free_i) begin
      used_d[free_addr_i] = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      used_q <= '0;
    end else begin
      used_q <= used_d;
    end
  end

endmodule

//--- hw/llbank_out_select.sv
/*
  Release arbiter of the queue bank, purely combinational.
  Picks the lowest enabled queue with a message and builds the output message.
*/
`include "llbank_defines.svh"

module llbank_out_select (
  input  llbank_pkg::id_mask_t cand_i,
  input  llbank_pkg::id_mask_t release_en_i,
  // Oldest payload per queue, or the incoming payload when the buffer is empty
  input  llbank_pkg::payload_t buf_payload_i [`LLB_NUM_IDS],
  input  logic                 out_ready_i,

  output llbank_pkg::id_mask_t grant_o,
  output logic                 out_valid_o,
  output llbank_pkg::msg_t     out_msg_o
);

  import llbank_pkg::*;

  id_mask_t req;
  id_mask_t sel;
  payload_t sel_payload;
  id_t      sel_id;

  // Queues allowed to leave this cycle
  assign req = cand_i & release_en_i;

  // Isolate the lowest set bit
  assign sel = req & (~req + 1'b1);

  // Valid never depends on ready
  assign out_valid_o = |sel;

  // Grant only while the message is taken downstream
  assign grant_o = sel & {`LLB_NUM_IDS{out_ready_i}};

  // One-hot mux of payload and encoded identifier
  always_comb begin
    sel_payload = '0;
    sel_id      = '0;
    for (int i = 0; i < `LLB_NUM_IDS; i++) begin
      if (sel[i]) begin
        sel_payload = sel_payload | buf_payload_i[i];
        sel_id      = sel_id | id_t'(i);
      end
    end
  end

  assign out_msg_o = '{payload: sel_payload, id: sel_id};

endmodule

//--- hw/llbank_list_ctrl.sv
/*
  Per-queue linked-list control of the response queue bank.
  Keeps heads, tails, lengths and one-entry output buffers, and drives both RAMs
  and the free map. A popped head is refilled from RAM on the following cycle.
*/
`include "llbank_defines.svh"

module llbank_list_ctrl (
  input  logic                 clk_i,
  input  logic                 rst_ni,

  // Input handshake
  input  logic                 in_valid_i,
  input  llbank_pkg::msg_t     in_msg_i,
  output logic                 in_ready_o,

  // From the arbiter and the output handshake
  input  llbank_pkg::id_mask_t grant_i,
  input  logic                 out_fire_i,

  // Free map
  input  llbank_pkg::addr_t    next_free_i,
  input  logic                 has_free_i,
  output logic                 alloc_o,
  output logic                 free_o,
  output llbank_pkg::addr_t    free_addr_o,

  // To the arbiter
  output llbank_pkg::id_mask_t cand_o,
  output llbank_pkg::payload_t buf_payload_o [`LLB_NUM_IDS],

  // Payload RAM
  output logic                 pay_wr_en_o,
  output llbank_pkg::addr_t    pay_wr_addr_o,
  output llbank_pkg::payload_t pay_wr_data_o,
  output logic                 pay_rd_en_o,
  output llbank_pkg::addr_t    pay_rd_addr_o,
  input  llbank_pkg::payload_t pay_rd_data_i,

  // Next-pointer RAM
  output logic                 nxt_wr_en_o,
  output llbank_pkg::addr_t    nxt_wr_addr_o,
  output llbank_pkg::addr_t    nxt_wr_data_o,
  output logic                 nxt_rd_en_o,
  output llbank_pkg::addr_t    nxt_rd_addr_o,
  input  llbank_pkg::addr_t    nxt_rd_data_i
);

  import llbank_pkg::*;

  localparam int NumIds = `LLB_NUM_IDS;

  // List state per queue
  addr_t    head_q   [NumIds];
  addr_t    head_d   [NumIds];
  addr_t    head_act [NumIds];
  addr_t    tail_q   [NumIds];
  addr_t    tail_d   [NumIds];
  len_t     len_q    [NumIds];
  len_t     len_d    [NumIds];

  // Output buffers hold the oldest message of each queue
  payload_t buf_q    [NumIds];
  payload_t buf_d    [NumIds];
  payload_t buf_act  [NumIds];
  id_mask_t buf_vld_q;
  id_mask_t buf_vld_d;

  // Set for one cycle after a RAM read for that queue
  id_mask_t head_from_ram_q;
  id_mask_t head_from_ram_d;
  id_mask_t buf_from_ram_q;
  id_mask_t buf_from_ram_d;

  // Per-queue actions of this cycle
  id_mask_t push_sel;
  id_mask_t push_ram;
  id_mask_t pop_ram;
  id_mask_t link;

  logic     in_fire;
  id_t      in_id;
  payload_t in_payload;
  addr_t    rd_addr;
  addr_t    link_addr;

  // Accept only while a RAM entry is left
  assign in_ready_o = has_free_i;
  assign in_fire    = in_valid_i && in_ready_o;
  assign in_id      = in_msg_i.id;
  assign in_payload = in_msg_i.payload;

  // RAM data gives the actual head and buffer right after a read
  always_comb begin
    for (int i = 0; i < NumIds; i++) begin
      head_act[i] = head_from_ram_q[i] ? nxt_rd_data_i : head_q[i];
      buf_act[i]  = buf_from_ram_q[i] ? pay_rd_data_i : buf_q[i];
      push_sel[i] = in_fire && (in_id == id_t'(i));
      cand_o[i]   = buf_vld_q[i] || push_sel[i];
      // Empty buffer forwards the incoming payload for pass-through
      buf_payload_o[i] = buf_vld_q[i] ? buf_act[i] : in_payload;
    end
  end

  always_comb begin
    logic pop;
    for (int i = 0; i < NumIds; i++) begin
      pop                = out_fire_i && grant_i[i];
      head_d[i]          = head_act[i];
      tail_d[i]          = tail_q[i];
      buf_d[i]           = buf_act[i];
      buf_vld_d[i]       = buf_vld_q[i];
      head_from_ram_d[i] = 1'b0;
      buf_from_ram_d[i]  = 1'b0;
      push_ram[i]        = 1'b0;
      pop_ram[i]         = 1'b0;
      link[i]            = 1'b0;

      // A popped buffer refills from the list if there is one
      if (pop && buf_vld_q[i]) begin
        if (len_q[i] != '0) begin
          pop_ram[i]         = 1'b1;
          buf_from_ram_d[i]  = 1'b1;
          // No next pointer to follow when the last element leaves
          head_from_ram_d[i] = len_q[i] > len_t'(1);
        end else if (push_sel[i]) begin
          buf_d[i] = in_payload;
        end else begin
          buf_vld_d[i] = 1'b0;
        end
      end

      if (push_sel[i]) begin
        if (!buf_vld_q[i]) begin
          // Fill the empty buffer unless the message passes straight through
          if (!pop) begin
            buf_vld_d[i] = 1'b1;
            buf_d[i]     = in_payload;
          end
        end else if (!(pop && len_q[i] == '0)) begin
          push_ram[i] = 1'b1;
          if (len_q[i] > len_t'(1) || (len_q[i] == len_t'(1) && !pop)) begin
            // Append behind the current tail
            link[i]   = 1'b1;
            tail_d[i] = next_free_i;
          end else begin
            // Start a fresh list when it is empty or drains this cycle
            head_d[i] = next_free_i;
            tail_d[i] = next_free_i;
          end
        end
      end

      len_d[i] = len_q[i] + len_t'(push_ram[i]) - len_t'(pop_ram[i]);
    end
  end

  // One pop and one push at most per cycle make plain one-hot muxes enough
  always_comb begin
    rd_addr   = '0;
    link_addr = '0;
    for (int i = 0; i < NumIds; i++) begin
      if (pop_ram[i]) begin
        rd_addr = rd_addr | head_act[i];
      end
      if (link[i]) begin
        link_addr = link_addr | tail_q[i];
      end
    end
  end

  // Both RAMs are read at the head being popped
  assign pay_wr_en_o   = |push_ram;
  assign pay_wr_addr_o = next_free_i;
  assign pay_wr_data_o = in_payload;
  assign pay_rd_en_o   = |pop_ram;
  assign pay_rd_addr_o = rd_addr;

  assign nxt_wr_en_o   = |link;
  assign nxt_wr_addr_o = link_addr;
  assign nxt_wr_data_o = next_free_i;
  assign nxt_rd_en_o   = |pop_ram;
  assign nxt_rd_addr_o = rd_addr;

  // Free map strobes
  assign alloc_o     = |push_ram;
  assign free_o      = |pop_ram;
  assign free_addr_o = rd_addr;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NumIds; i++) begin
        head_q[i] <= '0;
        tail_q[i] <= '0;
        len_q[i]  <= '0;
      end
      buf_vld_q       <= '0;
      head_from_ram_q <= '0;
      buf_from_ram_q  <= '0;
    end else begin
      for (int i = 0; i < NumIds; i++) begin
        head_q[i] <= head_d[i];
        tail_q[i] <= tail_d[i];
        len_q[i]  <= len_d[i];
      end
      buf_vld_q       <= buf_vld_d;
      head_from_ram_q <= head_from_ram_d;
      buf_from_ram_q  <= buf_from_ram_d;
    end
  end

  // Output buffer payloads
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < NumIds; i++) begin
      buf_q[i] <= buf_d[i];
    end
  end

endmodule

//--- hw/llbank_top.sv
/*
  Response queue bank, one in-order queue per identifier over shared storage.
  Messages enter and leave through valid/ready handshakes; release_en_i gates each queue.
*/
`include "llbank_defines.svh"

module llbank_top (
  input  logic                 clk_i,
  input  logic                 rst_ni,

  input  llbank_pkg::id_mask_t release_en_i,

  input  logic                 in_valid_i,
  output logic                 in_ready_o,
  input  llbank_pkg::msg_t     in_msg_i,

  output logic                 out_valid_o,
  input  logic                 out_ready_i,
  output llbank_pkg::msg_t     out_msg_o
);

  import llbank_pkg::*;

  // Free map
  logic     alloc;
  logic     free;
  addr_t    free_addr;
  addr_t    next_free;
  logic     has_free;

  // Arbiter
  id_mask_t cand;
  id_mask_t grant;
  payload_t buf_payload [`LLB_NUM_IDS];
  logic     out_fire;

  // RAM ports
  logic     pay_wr_en;
  addr_t    pay_wr_addr;
  payload_t pay_wr_data;
  logic     pay_rd_en;
  addr_t    pay_rd_addr;
  payload_t pay_rd_data;
  logic     nxt_wr_en;
  addr_t    nxt_wr_addr;
  addr_t    nxt_wr_data;
  logic     nxt_rd_en;
  addr_t    nxt_rd_addr;
  addr_t    nxt_rd_data;

  // Output handshake
  assign out_fire = out_valid_o && out_ready_i;

  llbank_list_ctrl u_list_ctrl (
    .clk_i, .rst_ni, .in_valid_i, .in_msg_i, .in_ready_o,
    .grant_i(grant), .out_fire_i(out_fire),
    .next_free_i(next_free), .has_free_i(has_free),
    .alloc_o(alloc), .free_o(free), .free_addr_o(free_addr),
    .cand_o(cand), .buf_payload_o(buf_payload),
    .pay_wr_en_o(pay_wr_en), .pay_wr_addr_o(pay_wr_addr), .pay_wr_data_o(pay_wr_data),
    .pay_rd_en_o(pay_rd_en), .pay_rd_addr_o(pay_rd_addr), .pay_rd_data_i(pay_rd_data),
    .nxt_wr_en_o(nxt_wr_en), .nxt_wr_addr_o(nxt_wr_addr), .nxt_wr_data_o(nxt_wr_data),
    .nxt_rd_en_o(nxt_rd_en), .nxt_rd_addr_o(nxt_rd_addr), .nxt_rd_data_i(nxt_rd_data)
  );

  llbank_free_map u_free_map (
    .clk_i, .rst_ni, .alloc_i(alloc), .free_i(free), .free_addr_i(free_addr),
    .next_free_o(next_free), .has_free_o(has_free)
  );

  llbank_out_select u_out_select (
    .cand_i(cand), .release_en_i, .buf_payload_i(buf_payload), .out_ready_i,
    .grant_o(grant), .out_valid_o, .out_msg_o
  );

  // Message bodies
  llbank_ram_2p #(.Width($bits(payload_t)), .Depth(`LLB_CAPACITY)) u_pay_ram (
    .clk_i, .wr_en_i(pay_wr_en), .wr_addr_i(pay_wr_addr), .wr_data_i(pay_wr_data),
    .rd_en_i(pay_rd_en), .rd_addr_i(pay_rd_addr), .rd_data_o(pay_rd_data)
  );

  // Successor links of the per-queue lists
  llbank_ram_2p #(.Width(`LLB_ADDR_WIDTH), .Depth(`LLB_CAPACITY)) u_nxt_ram (
    .clk_i, .wr_en_i(nxt_wr_en), .wr_addr_i(nxt_wr_addr), .wr_data_i(nxt_wr_data),
    .rd_en_i(nxt_rd_en), .rd_addr_i(nxt_rd_addr), .rd_data_o(nxt_rd_data)
  );

endmodule

//--- dv/tb_llbank.sv
/*
  Self-checking testbench of the response queue bank.
  Keeps one model queue per identifier and checks order, priority, release blocking,
  capacity, back-pressure and pass-through. Top module tb_llbank, DUT llbank_top.
*/
`include "llbank_defines.svh"

module tb_llbank;

  import llbank_pkg::*;

  localparam int NumIds    = `LLB_NUM_IDS;
  localparam int Capacity  = `LLB_CAPACITY;
  localparam int WaitLimit = 2000;

  logic     clk_i;
  logic     rst_ni;
  id_mask_t release_en_i;
  logic     in_valid_i;
  logic     in_ready_o;
  msg_t     in_msg_i;
  logic     out_valid_o;
  logic     out_ready_i;
  msg_t     out_msg_o;

  // One reference queue per identifier with the oldest payload in front
  payload_t model_q [NumIds][$];

  // Raised by the monitor once in_ready_o is seen low
  logic     full_seen;

  llbank_top UUT (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .release_en_i (release_en_i),
    .in_valid_i   (in_valid_i),
    .in_ready_o   (in_ready_o),
    .in_msg_i     (in_msg_i),
    .out_valid_o  (out_valid_o),
    .out_ready_i  (out_ready_i),
    .out_msg_o    (out_msg_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // Lowest enabled identifier holding a message or -1 when there is none
  function automatic int expected_grant(id_mask_t occ, id_mask_t mask);
    for (int i = 0; i < NumIds; i++) begin
      if (occ[i] && mask[i]) begin
        return i;
      end
    end
    return -1;
  endfunction

  function automatic id_mask_t occupancy();
    id_mask_t occ;
    for (int i = 0; i < NumIds; i++) begin
      occ[i] = model_q[i].size() != 0;
    end
    return occ;
  endfunction

  // Everything except the oldest message of a queue lives in RAM
  function automatic int ram_held();
    int n;
    n = 0;
    for (int i = 0; i < NumIds; i++) begin
      if (model_q[i].size() > 1) begin
        n += model_q[i].size() - 1;
      end
    end
    return n;
  endfunction

  function automatic int total_queued();
    int n;
    n = 0;
    for (int i = 0; i < NumIds; i++) begin
      n += model_q[i].size();
    end
    return n;
  endfunction

  // Sampled mid-cycle where inputs and outputs are settled
  always @(negedge clk_i) begin : monitor
    int exp_id;
    if (rst_ni) begin
      assert (in_ready_o == (ram_held() < Capacity)) else begin
        $display("mismatch at time %0t: in_ready_o=%0b with %0d messages in RAM",
                 $time, in_ready_o, ram_held());
        $display("Simulation FAILED");
        $fatal(1);
      end
      if (!in_ready_o) begin
        full_seen = 1'b1;
      end
      // A message accepted on this edge already counts as queued
      if (in_valid_i && in_ready_o) begin
        model_q[in_msg_i.id].push_back(in_msg_i.payload);
      end
      exp_id = expected_grant(occupancy(), release_en_i);
      assert (out_valid_o == (exp_id >= 0)) else begin
        $display("mismatch at time %0t: out_valid_o=%0b, expected grant %0d",
                 $time, out_valid_o, exp_id);
        $display("Simulation FAILED");
        $fatal(1);
      end
      if (out_valid_o) begin
        assert (out_msg_o.id == id_t'(exp_id)) else begin
          $display("mismatch at time %0t: output id %0d, expected %0d",
                   $time, out_msg_o.id, exp_id);
          $display("Simulation FAILED");
          $fatal(1);
        end
        assert (out_msg_o.payload == model_q[exp_id][0]) else begin
          $display("mismatch at time %0t: id %0d payload %h, expected %h",
                   $time, exp_id, out_msg_o.payload, model_q[exp_id][0]);
          $display("Simulation FAILED");
          $fatal(1);
        end
        if (out_ready_i) begin
          void'(model_q[exp_id].pop_front());
        end
      end
    end
  end

  // One push for the given identifier on the next rising edge
  task automatic drive_msg(id_t id);
    @(posedge clk_i);
    in_valid_i <= 1'b1;
    in_msg_i   <= '{payload: payload_t'($urandom), id: id};
  endtask

  // Stop pushing and set the output side
  task automatic go_idle(id_mask_t mask, logic ready);
    @(posedge clk_i);
    in_valid_i   <= 1'b0;
    release_en_i <= mask;
    out_ready_i  <= ready;
  endtask

  task automatic wait_drained();
    int cycles;
    cycles = 0;
    while (total_queued() != 0) begin
      @(posedge clk_i);
      cycles++;
      if (cycles > WaitLimit) begin
        $display("Timeout: the queues did not drain");
        $display("Simulation FAILED");
        $fatal(1);
      end
    end
  endtask

  // Round robin over identifiers 0 to 3 until the RAM is full
  task automatic fill_until_full();
    int cycles;
    cycles = 0;
    full_seen = 1'b0;
    while (!full_seen) begin
      drive_msg(id_t'(cycles % 4));
      cycles++;
      if (cycles > WaitLimit) begin
        $display("Timeout: in_ready_o never fell while filling the RAM");
        $display("Simulation FAILED");
        $fatal(1);
      end
    end
    go_idle('0, 1'b0);
  endtask

  initial begin
    msg_t held;
    void'($urandom(62));
    rst_ni       = 1'b0;
    release_en_i = '0;
    in_valid_i   = 1'b0;
    in_msg_i     = '0;
    out_ready_i  = 1'b0;
    full_seen    = 1'b0;
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;

    // Random traffic, masks and back-pressure
    repeat (600) begin
      @(posedge clk_i);
      in_valid_i   <= ($urandom % 2) == 0;
      in_msg_i     <= '{payload: payload_t'($urandom), id: id_t'($urandom)};
      release_en_i <= id_mask_t'($urandom);
      out_ready_i  <= ($urandom % 4) != 0;
    end
    go_idle('1, 1'b1);
    wait_drained();

    // Identifier 5 blocked while 2 and 12 flow
    go_idle(~id_mask_t'(1 << 5), 1'b1);
    for (int k = 0; k < 6; k++) begin
      drive_msg(id_t'(5));
      drive_msg(id_t'(2 + 10 * (k % 2)));
    end
    go_idle(~id_mask_t'(1 << 5), 1'b1);
    repeat (8) @(negedge clk_i);
    assert (!out_valid_o && model_q[5].size() == 6 && total_queued() == 6) else begin
      $display("mismatch at time %0t: out_valid_o=%0b, %0d queued for id 5, %0d in total",
               $time, out_valid_o, model_q[5].size(), total_queued());
      $display("Simulation FAILED");
      $fatal(1);
    end
    go_idle('1, 1'b1);
    wait_drained();

    // Capacity with every release bit low
    go_idle('0, 1'b0);
    fill_until_full();
    @(negedge clk_i);
    assert (!in_ready_o && ram_held() == Capacity && total_queued() == Capacity + 4) else begin
      $display("mismatch at time %0t: in_ready_o=%0b with %0d in RAM and %0d in total",
               $time, in_ready_o, ram_held(), total_queued());
      $display("Simulation FAILED");
      $fatal(1);
    end

    // Output held under back-pressure
    go_idle('1, 1'b0);
    @(negedge clk_i);
    held = out_msg_o;
    repeat (5) begin
      @(negedge clk_i);
      assert (out_valid_o && out_msg_o == held) else begin
        $display("mismatch at time %0t: output moved from %h to %h under back-pressure",
                 $time, held, out_msg_o);
        $display("Simulation FAILED");
        $fatal(1);
      end
    end
    go_idle('1, 1'b1);
    wait_drained();

    // Pass-through on an empty enabled queue
    drive_msg(id_t'(7));
    @(negedge clk_i);
    assert (in_ready_o && out_valid_o && out_msg_o == in_msg_i) else begin
      $display("mismatch at time %0t: output %h, expected pass-through of %h",
               $time, out_msg_o, in_msg_i);
      $display("Simulation FAILED");
      $fatal(1);
    end
    go_idle('1, 1'b1);
    wait_drained();
    repeat (4) @(posedge clk_i);

    $display("Simulation PASSED");
    $finish;
  end

endmodule

//--- flist.f
+incdir+include
hw/llbank_pkg.sv
hw/llbank_ram_2p.sv
hw/llbank_free_map.sv
hw/llbank_out_select.sv
hw/llbank_list_ctrl.sv
hw/llbank_top.sv
dv/tb_llbank.sv

//--- Bender.yml
package:
  name: llbank

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/llbank_pkg.sv
      - hw/llbank_ram_2p.sv
      - hw/llbank_free_map.sv
      - hw/llbank_out_select.sv
      - hw/llbank_list_ctrl.sv
      - hw/llbank_top.sv

  - target: test
    include_dirs:
      - include
    files:
      - dv/tb_llbank.sv
